// ==== all.f ====
snd_pkg.sv
snd_regs.sv
pcm_fifo.sv
psg_tone.sv
dc_remover.sv
snd_mixer.sv
snd_board.sv
snd_board_checker.sv
tb_snd_board.sv

// ==== dc_remover.sv ====
// DC removal for the tone channel
// first-order running average subtracted, result left-justified to 16 bits
`timescale 1ns/1ns

module dc_remover (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  snd_pkg::psg_t    din,
    output snd_pkg::sample_t dout
);

    snd_pkg::sample_t avg;      // signed running average
    snd_pkg::sample_t din_s;
    snd_pkg::sample_t diff;

    assign din_s = $signed({6'd0, din});
    assign diff  = din_s - avg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            avg  <= '0;
            dout <= '0;
        end else if (cen) begin
            avg <= avg + (diff >>> snd_pkg::DCRM_SHIFT);
            // +512 would land one past full scale after the shift
            if (diff > 16'sd511)
                dout <= 16'sh7fff;
            else
                dout <= diff <<< 6;
        end
    end

endmodule

// ==== pcm_fifo.sv ====
// PCM sample FIFO
// filled by CPU high-byte writes, drained once per output sample
`timescale 1ns/1ns

module pcm_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  snd_pkg::sample_t din,
    input  logic             pop,
    output snd_pkg::sample_t dout
);

    snd_pkg::sample_t             mem [snd_pkg::FIFO_DEPTH];
    logic [snd_pkg::FIFO_AW-1:0]  wr_ptr;
    logic [snd_pkg::FIFO_AW-1:0]  rd_ptr;
    logic [snd_pkg::FIFO_AW:0]    count;
    logic                         full;
    logic                         empty;
    logic                         do_push;
    logic                         do_pop;

    assign full    = count == snd_pkg::FIFO_DEPTH;
    assign empty   = count == 0;
    assign do_push = push && !full;     // overflow writes dropped
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            dout   <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (pop)
                dout <= do_pop ? mem[rd_ptr] : '0;  // underrun gives silence
        end
    end

endmodule

// ==== psg_tone.sv ====
// square tone generator
// toggles between 0 and PSG_AMP every period samples
`timescale 1ns/1ns

module psg_tone (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cen,
    input  logic [7:0]    period,
    output snd_pkg::psg_t level
);

    logic [7:0] cnt;
    logic [7:0] cnt_nx;

    assign cnt_nx = cnt + 8'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            level <= '0;
        end else if (cen) begin
            if (period == 8'd0) begin
                cnt   <= '0;            // silent, output held low
                level <= '0;
            end else if (cnt_nx == period) begin
                cnt   <= '0;
                level <= (level == '0) ? snd_pkg::PSG_AMP : '0;
            end else begin
                cnt <= cnt_nx;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the sound board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_snd_board -o sim_snd_board

out=$(./obj_dir/sim_snd_board 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// ==== snd_board.sv ====
// sound board output stage
// register file, PCM FIFO, tone channel and mixer on a divided sample rate
`timescale 1ns/1ns

module snd_board (
    input  logic              clk,
    input  logic              rst_n,
    input  snd_pkg::cpu_wr_t  cpu_wr,
    output snd_pkg::sample_t  snd,
    output logic              sample,
    output logic              peak
);

    logic [snd_pkg::DIV_W-1:0] div_cnt;
    logic                      cen_snd;
    snd_pkg::sample_t          fm_smp;
    logic [7:0]                tone_period;
    snd_pkg::ch_en_t           ch_en;
    snd_pkg::gain_t            fm_gain;
    logic                      pcm_push;
    snd_pkg::sample_t          pcm_data;
    snd_pkg::sample_t          pcm_smp;
    snd_pkg::psg_t             psg_raw;
    snd_pkg::sample_t          psg_ac;
    snd_pkg::snd_frame_t       frame;

    // sample rate enable, first pulse SAMPLE_DIV-1 clocks out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            div_cnt <= '0;
        else if (cen_snd)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign cen_snd = div_cnt == snd_pkg::SAMPLE_DIV - 1;

    snd_regs u_regs (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cpu_wr      ( cpu_wr      ),
        .fm_smp      ( fm_smp      ),
        .tone_period ( tone_period ),
        .ch_en       ( ch_en       ),
        .fm_gain     ( fm_gain     ),
        .pcm_push    ( pcm_push    ),
        .pcm_data    ( pcm_data    )
    );

    pcm_fifo u_fifo (
        .clk   ( clk      ),
        .rst_n ( rst_n    ),
        .push  ( pcm_push ),
        .din   ( pcm_data ),
        .pop   ( cen_snd  ),
        .dout  ( pcm_smp  )
    );

    psg_tone u_tone (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .cen    ( cen_snd     ),
        .period ( tone_period ),
        .level  ( psg_raw     )
    );

    dc_remover u_dcrm (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .cen   ( cen_snd ),
        .din   ( psg_raw ),
        .dout  ( psg_ac  )
    );

    assign frame.fm  = fm_smp;
    assign frame.pcm = pcm_smp;
    assign frame.psg = psg_ac;
    assign frame.en  = ch_en;

    snd_mixer u_mixer (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cen     ( cen_snd ),
        .frame   ( frame   ),
        .fm_gain ( fm_gain ),
        .snd     ( snd     ),
        .sample  ( sample  ),
        .peak    ( peak    )
    );

endmodule

// ==== snd_board_checker.sv ====
// assertions on the sound board outputs
// strobe width, strobe spacing and peak update timing
`timescale 1ns/1ns

module snd_board_checker (
    input logic clk,
    input logic rst_n,
    input logic sample,
    input logic peak
);

    logic [7:0] gap;    // clocks since the last strobe
    logic       seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gap  <= '0;
            seen <= 1'b0;
        end else if (sample) begin
            gap  <= 8'd1;
            seen <= 1'b1;
        end else if (gap != 8'hff) begin
            gap <= gap + 8'd1;
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) sample |=> !sample)
        else $error("sample strobe high on two consecutive clocks");

    // peak is loaded on the same edge that raises sample
    a_peak_timing: assert property (@(posedge clk) disable iff (!rst_n) !$stable(peak) |-> sample)
        else $error("peak changed away from a sample clock");

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !sample)
        else $error("sample high during reset");

    a_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        (sample && seen) |-> gap == 8'(snd_pkg::SAMPLE_DIV))
        else $error("sample strobe spacing differs from the divider");

    a_no_missing: assert property (@(posedge clk) disable iff (!rst_n)
        seen |-> gap <= 8'(snd_pkg::SAMPLE_DIV))
        else $error("sample strobe missing");

endmodule

// ==== snd_mixer.sv ====
// three channel mixer
// 4.4 gains, channel enables, saturation to 16 bits and peak flag
`timescale 1ns/1ns

module snd_mixer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cen,
    input  snd_pkg::snd_frame_t frame,
    input  snd_pkg::gain_t      fm_gain,
    output snd_pkg::sample_t    snd,
    output logic                sample,
    output logic                peak
);

    logic               cen_d;      // sources settled one clock after cen
    logic signed [20:0] fm_sc;
    logic signed [20:0] pcm_sc;
    logic signed [20:0] psg_sc;
    logic signed [22:0] acc;        // wide enough for three full-scale terms
    logic               over;
    logic               under;

    // gain in 4.4, product shifted back by the fraction bits
    function automatic logic signed [20:0] scale(
        input snd_pkg::sample_t s,
        input snd_pkg::gain_t   g,
        input logic             en
    );
        logic signed [24:0] prod;
        prod = s * $signed({1'b0, g});
        return en ? prod[24:4] : '0;
    endfunction

    assign fm_sc  = scale(frame.fm,  fm_gain,           frame.en.fm);
    assign pcm_sc = scale(frame.pcm, snd_pkg::PCM_GAIN, frame.en.pcm);
    assign psg_sc = scale(frame.psg, snd_pkg::PSG_GAIN, frame.en.psg);

    assign acc   = fm_sc + pcm_sc + psg_sc;
    assign over  = acc > 23'sd32767;
    assign under = acc < -23'sd32768;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_d  <= 1'b0;
            sample <= 1'b0;
            snd    <= '0;
            peak   <= 1'b0;
        end else begin
            cen_d  <= cen;
            sample <= cen_d;
            if (cen_d) begin
                peak <= over || under;
                if (over)
                    snd <= 16'sh7fff;
                else if (under)
                    snd <= 16'sh8000;
                else
                    snd <= acc[15:0];
            end
        end
    end

endmodule

// ==== snd_pkg.sv ====
// sound board shared definitions
// sample formats, CPU register map, mixer gains, divider and FIFO sizes
package snd_pkg;

    typedef logic signed [15:0] sample_t;   // signed audio sample
    typedef logic        [9:0]  psg_t;      // raw unsigned tone level
    typedef logic        [7:0]  gain_t;     // 4.4 fixed point, 8'h10 is unity
    typedef logic        [2:0]  reg_addr_t;

    typedef struct packed {
        logic       wr;     // single-cycle write strobe
        reg_addr_t  addr;
        logic [7:0] data;
    } cpu_wr_t;

    typedef struct packed {
        logic fm;
        logic pcm;
        logic psg;
    } ch_en_t;

    // mixer input, one sample per channel plus enables
    typedef struct packed {
        sample_t fm;
        sample_t pcm;
        sample_t psg;
        ch_en_t  en;
    } snd_frame_t;

    localparam reg_addr_t ADDR_FM_LO  = 3'd0;
    localparam reg_addr_t ADDR_FM_HI  = 3'd1;   // commits FM sample
    localparam reg_addr_t ADDR_PCM_LO = 3'd2;
    localparam reg_addr_t ADDR_PCM_HI = 3'd3;   // pushes PCM pair
    localparam reg_addr_t ADDR_TONE   = 3'd4;   // half-period in samples
    localparam reg_addr_t ADDR_CTRL   = 3'd5;

    // control register bits, fxlevel sits in [1:0]
    localparam int CTRL_FM_BIT  = 2;
    localparam int CTRL_PSG_BIT = 3;
    localparam int CTRL_PCM_BIT = 4;

    localparam gain_t FM_GAIN_TABLE [4] = '{8'h18, 8'h20, 8'h28, 8'h30};
    localparam gain_t PCM_GAIN = 8'h10;
    localparam gain_t PSG_GAIN = 8'h10;

    localparam int SAMPLE_DIV = 16;             // clocks per output sample
    localparam int DIV_W      = $clog2(SAMPLE_DIV);
    localparam int FIFO_DEPTH = 8;              // power of two
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam psg_t PSG_AMP  = 10'h200;
    localparam int DCRM_SHIFT = 4;

endpackage

// ==== snd_regs.sv ====
// sound CPU register file
// FM sample, tone period, control bits and the fxlevel to FM gain lookup
`timescale 1ns/1ns

module snd_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  snd_pkg::cpu_wr_t  cpu_wr,
    output snd_pkg::sample_t  fm_smp,
    output logic [7:0]        tone_period,
    output snd_pkg::ch_en_t   ch_en,
    output snd_pkg::gain_t    fm_gain,
    output logic              pcm_push,
    output snd_pkg::sample_t  pcm_data
);

    logic [7:0] fm_lo;      // low byte staging
    logic [7:0] pcm_lo;
    logic       wr_fm_lo;
    logic       wr_fm_hi;
    logic       wr_pcm_lo;
    logic       wr_pcm_hi;
    logic       wr_tone;
    logic       wr_ctrl;

    assign wr_fm_lo  = cpu_wr.wr && (cpu_wr.addr == snd_pkg::ADDR_FM_LO);
    assign wr_fm_hi  = cpu_wr.wr && (cpu_wr.addr == snd_pkg::ADDR_FM_HI);
    assign wr_pcm_lo = cpu_wr.wr && (cpu_wr.addr == snd_pkg::ADDR_PCM_LO);
    assign wr_pcm_hi = cpu_wr.wr && (cpu_wr.addr == snd_pkg::ADDR_PCM_HI);
    assign wr_tone   = cpu_wr.wr && (cpu_wr.addr == snd_pkg::ADDR_TONE);
    assign wr_ctrl   = cpu_wr.wr && (cpu_wr.addr == snd_pkg::ADDR_CTRL);

    always_ff @(posedge clk) begin
        if (wr_fm_lo)  fm_lo  <= cpu_wr.data;
        if (wr_pcm_lo) pcm_lo <= cpu_wr.data;
        if (wr_pcm_hi) pcm_data <= {cpu_wr.data, pcm_lo};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_smp      <= '0;
            tone_period <= '0;      // tone held low
            ch_en       <= '0;
            fm_gain     <= snd_pkg::FM_GAIN_TABLE[0];
            pcm_push    <= 1'b0;
        end else begin
            pcm_push <= wr_pcm_hi;  // one pulse per high byte
            if (wr_fm_hi)
                fm_smp <= {cpu_wr.data, fm_lo};
            if (wr_tone)
                tone_period <= cpu_wr.data;
            if (wr_ctrl) begin
                ch_en.fm  <= cpu_wr.data[snd_pkg::CTRL_FM_BIT];
                ch_en.pcm <= cpu_wr.data[snd_pkg::CTRL_PCM_BIT];
                ch_en.psg <= cpu_wr.data[snd_pkg::CTRL_PSG_BIT];
                // gain looked up straight from the written fxlevel
                fm_gain   <= snd_pkg::FM_GAIN_TABLE[cpu_wr.data[1:0]];
            end
        end
    end

endmodule

// ==== tb_snd_board.sv ====
// testbench for the sound board output stage
// random CPU writes checked sample by sample against a reference model
`timescale 1ns/1ns

module tb_snd_board;

    localparam int WINDOW  = snd_pkg::SAMPLE_DIV - 4;   // writes allowed after a strobe
    localparam int TIMEOUT = 4 * snd_pkg::SAMPLE_DIV;

    logic             clk;
    logic             rst_n;
    snd_pkg::cpu_wr_t cpu_wr;
    snd_pkg::sample_t snd;
    logic             sample;
    logic             peak;

    integer seed;
    string  test_name;
    int     test_checks;
    int     test_errors;
    int     total_checks;
    int     total_errors;
    int     win_writes;
    int     cyc;
    int     last_pulse;

    // reference model state
    int         m_fm;
    logic [7:0] m_fm_lo;
    logic [7:0] m_pcm_lo;
    int         m_gain;
    logic       m_en_fm;
    logic       m_en_pcm;
    logic       m_en_psg;
    int         m_period;
    int         m_cnt;
    int         m_level;
    int         m_avg;
    int         m_psg;
    int         m_pcm;
    int         m_fifo[$];

    snd_board i_snd_board (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .cpu_wr ( cpu_wr ),
        .snd    ( snd    ),
        .sample ( sample ),
        .peak   ( peak   )
    );

    bind snd_board snd_board_checker i_checker (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .sample ( sample ),
        .peak   ( peak   )
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // register side of the model applied as each write is issued
    task automatic model_write(input snd_pkg::reg_addr_t addr, input logic [7:0] data);
        int v;
        v = $signed({data, (addr == snd_pkg::ADDR_FM_HI) ? m_fm_lo : m_pcm_lo});
        case (addr)
            snd_pkg::ADDR_FM_LO:  m_fm_lo = data;
            snd_pkg::ADDR_FM_HI:  m_fm = v;
            snd_pkg::ADDR_PCM_LO: m_pcm_lo = data;
            snd_pkg::ADDR_PCM_HI: begin
                if (m_fifo.size() < snd_pkg::FIFO_DEPTH)
                    m_fifo.push_back(v);        // full queue drops the pair
            end
            snd_pkg::ADDR_TONE:   m_period = data;
            snd_pkg::ADDR_CTRL: begin
                m_en_fm  = data[2];
                m_en_psg = data[3];
                m_en_pcm = data[4];
                case (data[1:0])
                    2'd0:    m_gain = 24;
                    2'd1:    m_gain = 32;
                    2'd2:    m_gain = 40;
                    default: m_gain = 48;
                endcase
            end
            default: ;
        endcase
    endtask

    // one output sample in FIFO pop, DC step, tone step and mix order
    task automatic model_step(output int exp_snd, output logic exp_peak);
        int diff;
        int sum;
        m_pcm = (m_fifo.size() > 0) ? m_fifo.pop_front() : 0;
        diff  = m_level - m_avg;                   // tone level before this step
        m_psg = (diff > 511) ? 32767 : diff * 64;
        m_avg = m_avg + (diff >>> 4);
        if (m_period == 0) begin
            m_cnt   = 0;
            m_level = 0;
        end else if (((m_cnt + 1) & 255) == m_period) begin
            m_cnt   = 0;
            m_level = (m_level == 0) ? 512 : 0;
        end else begin
            m_cnt = (m_cnt + 1) & 255;
        end
        sum = 0;
        if (m_en_fm)  sum += (m_fm * m_gain) >>> 4;
        if (m_en_pcm) sum += (m_pcm * 16) >>> 4;  // unity gain
        if (m_en_psg) sum += (m_psg * 16) >>> 4;
        exp_peak = (sum > 32767) || (sum < -32768);
        if (sum > 32767)
            exp_snd = 32767;
        else if (sum < -32768)
            exp_snd = -32768;
        else
            exp_snd = sum;
    endtask

    task automatic check_sample();
        int   n;
        int   exp_snd;
        logic exp_peak;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (sample !== 1'b1 && n < TIMEOUT);
        if (sample !== 1'b1) begin
            $display("timeout: no sample strobe within %0d clocks in test %s", TIMEOUT,
                     test_name);
            $display("Verification failed");
            $finish;
        end else begin
            win_writes = 0;
            if (last_pulse >= 0) begin
                test_checks++;
                if (cyc - last_pulse != snd_pkg::SAMPLE_DIV) begin
                    $display("test %s: sample strobe came %0d clocks after the previous one",
                             test_name, cyc - last_pulse);
                    test_errors++;
                end
            end
            last_pulse = cyc;
            model_step(exp_snd, exp_peak);
            test_checks += 2;
            if (snd !== snd_pkg::sample_t'(exp_snd)) begin
                $display("MISMATCH test=%s snd expected=%0d actual=%0d", test_name,
                         exp_snd, snd);
                test_errors++;
            end
            if (peak !== exp_peak) begin
                $display("MISMATCH test=%s peak expected=%0b actual=%0b", test_name,
                         exp_peak, peak);
                test_errors++;
            end
        end
    endtask

    // one clock per write and a strobe wait once the window is used up
    task automatic write_reg(input snd_pkg::reg_addr_t addr, input logic [7:0] data);
        if (win_writes >= WINDOW)
            check_sample();
        cpu_wr.wr   = 1'b1;
        cpu_wr.addr = addr;
        cpu_wr.data = data;
        model_write(addr, data);
        @(posedge clk);
        #1;
        cpu_wr.wr = 1'b0;
        win_writes++;
    endtask

    task automatic write_fm(input logic [15:0] v);
        write_reg(snd_pkg::ADDR_FM_LO, v[7:0]);
        write_reg(snd_pkg::ADDR_FM_HI, v[15:8]);
    endtask

    task automatic write_pcm(input logic [15:0] v);
        write_reg(snd_pkg::ADDR_PCM_LO, v[7:0]);
        write_reg(snd_pkg::ADDR_PCM_HI, v[15:8]);
    endtask

    function automatic logic [15:0] near_full_scale();
        int v;
        v = rand_range(28000, 32767);
        if ($random(seed) & 1)
            v = -v;
        return 16'(v);
    endfunction

    task automatic end_test();
        $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks  = 0;
        test_errors  = 0;
    endtask

    initial begin
        int         n;
        logic [7:0] d;
        clk          = 1'b0;
        rst_n        = 1'b0;
        cpu_wr       = '0;
        seed         = 32'h4bf6_7d26;
        cyc          = 0;
        last_pulse   = -1;
        win_writes   = WINDOW;      // no write before the first strobe
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        m_fm         = 0;
        m_fm_lo      = '0;
        m_pcm_lo     = '0;
        m_gain       = 24;
        m_en_fm      = 1'b0;
        m_en_pcm     = 1'b0;
        m_en_psg     = 1'b0;
        m_period     = 0;
        m_cnt        = 0;
        m_level      = 0;
        m_avg        = 0;
        m_psg        = 0;
        m_pcm        = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "reset";
        test_checks += 2;
        if (snd !== 16'sd0) begin
            $display("MISMATCH test=%s snd expected=0 actual=%0d", test_name, snd);
            test_errors++;
        end
        if (peak !== 1'b0) begin
            $display("MISMATCH test=%s peak expected=0 actual=%0b", test_name, peak);
            test_errors++;
        end
        repeat (8) check_sample();
        end_test();

        test_name = "fm_gain";
        for (int lvl = 0; lvl < 4; lvl++) begin
            write_reg(snd_pkg::ADDR_CTRL, 8'(lvl) | 8'h04);
            for (int i = 0; i < 6; i++) begin
                write_fm(16'($random(seed)));
                check_sample();
            end
        end
        end_test();

        test_name = "pcm_fifo";
        write_reg(snd_pkg::ADDR_CTRL, 8'h10);
        for (int b = 0; b < 12; b++) begin
            n = (b == 0) ? 10 : rand_range(0, 10);  // first burst always overflows
            for (int i = 0; i < n; i++)
                write_pcm(16'($random(seed)));
            n = rand_range(1, 6);
            repeat (n) check_sample();  // short runs leave data behind and long ones underrun
        end
        repeat (snd_pkg::FIFO_DEPTH + 1) check_sample();
        end_test();

        test_name = "tone_dc";
        write_reg(snd_pkg::ADDR_CTRL, 8'h08);
        for (int seg = 0; seg < 4; seg++) begin
            write_reg(snd_pkg::ADDR_TONE, 8'(rand_range(0, 6)));
            repeat (16) check_sample();
        end
        end_test();

        test_name = "full_mix";
        for (int i = 0; i < 24; i++) begin
            d    = 8'($random(seed));
            d[1] = 1'b1;                // fxlevel 2 or 3
            write_reg(snd_pkg::ADDR_CTRL, d);
            write_fm(near_full_scale());
            write_pcm(near_full_scale());
            write_reg(snd_pkg::ADDR_TONE, 8'(rand_range(0, 4)));
            check_sample();
        end
        end_test();

        $display("checks: %0d passed, %0d failed", total_checks - total_errors, total_errors);
        if (total_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
